/* design/soc_bus_pkg.sv */
package soc_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;
    typedef logic [15:0] offset_t;  // Low address bits seen by a target

    localparam addr_t RAM_BASE    = 32'h0000_0000;
    localparam addr_t REGS_BASE   = 32'h0001_0000;
    localparam addr_t UART_BASE   = 32'h0002_0000;
    localparam addr_t REGION_MASK = 32'hffff_0000;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSTR,
        OWN_DATA
    } owner_t;

endpackage

/* design/soc_periph_pkg.sv */
package soc_periph_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  led_t;
    typedef logic [63:0] cycle_t;

    localparam int unsigned RAM_WORDS      = 256;
    localparam int unsigned RAM_INDEX_BITS = $clog2(RAM_WORDS);

    localparam logic [3:0] REG_LEDS     = 4'h0;
    localparam logic [3:0] REG_CYCLE_LO = 4'h4;
    localparam logic [3:0] REG_CYCLE_HI = 4'h8;
    localparam logic [3:0] UART_DATA    = 4'h0;
    localparam logic [3:0] UART_STATUS  = 4'h4;

    localparam int unsigned UART_DIV      = 8;  // Clock cycles per serial bit
    localparam int unsigned UART_CNT_BITS = $clog2(UART_DIV);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

endpackage

/* design/bus_ifs.sv */
interface mem_bus_if;
    import soc_bus_pkg::*;

    addr_t address;
    logic  read;
    logic  write;
    mask_t write_mask;
    word_t write_value;
    word_t read_value;
    logic  ready;

    modport host (output address, read, write, write_mask, write_value,
                  input read_value, ready);
    modport target (input address, read, write, write_mask, write_value,
                    output read_value, ready);
endinterface

interface periph_if;
    import soc_bus_pkg::*;

    offset_t offset;
    logic    write;
    mask_t   write_mask;
    word_t   write_value;
    logic    strobe;
    word_t   read_value;

    modport host (output offset, write, write_mask, write_value, strobe, input read_value);
    modport target (input offset, write, write_mask, write_value, strobe, output read_value);
endinterface

/* design/bus_arbiter.sv */
module bus_arbiter (
    input  logic               pll_clk,
    input  logic               reset,
    input  soc_bus_pkg::addr_t instr_address,
    input  logic               instr_read,
    output soc_bus_pkg::word_t instr_read_value,
    output logic               instr_ready,
    input  soc_bus_pkg::addr_t data_address,
    input  logic               data_read,
    input  logic               data_write,
    input  soc_bus_pkg::mask_t data_write_mask,
    input  soc_bus_pkg::word_t data_write_value,
    output soc_bus_pkg::word_t data_read_value,
    output logic               data_ready,
    mem_bus_if.host            bus
);
    import soc_bus_pkg::*;

    owner_t owner;
    owner_t grant;

    always_comb begin
        grant = owner;
        if (owner == OWN_NONE) begin
            if (data_read || data_write)
                grant = OWN_DATA;  // Data port wins a tie
            else if (instr_read)
                grant = OWN_INSTR;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            owner <= OWN_NONE;
        end else if (bus.ready) begin
            owner <= OWN_NONE;  // Transaction done, free the bus
        end else begin
            owner <= grant;
        end
    end

    always_comb begin
        bus.address     = instr_address;
        bus.read        = 1'b0;
        bus.write       = 1'b0;
        bus.write_mask  = '0;
        bus.write_value = '0;
        case (grant)
            OWN_INSTR: bus.read = instr_read;
            OWN_DATA: begin
                bus.address     = data_address;
                bus.read        = data_read;
                bus.write       = data_write;
                bus.write_mask  = data_write_mask;
                bus.write_value = data_write_value;
            end
            default: ;
        endcase
    end

    assign instr_ready      = bus.ready && owner == OWN_INSTR;
    assign data_ready       = bus.ready && owner == OWN_DATA;
    assign instr_read_value = instr_ready ? bus.read_value : '0;
    assign data_read_value  = data_ready ? bus.read_value : '0;

    // Every bus ready goes back to exactly one master, never both
    assert property (@(posedge pll_clk) disable iff (reset)
        bus.ready |-> $onehot({instr_ready, data_ready}))
        else $error("Bus ready not returned to exactly one master");

endmodule

/* design/bus_decoder.sv */
module bus_decoder (
    input  logic      pll_clk,
    input  logic      reset,
    mem_bus_if.target bus,
    periph_if.host    ram_port,
    periph_if.host    regs_port,
    periph_if.host    uart_port
);
    import soc_bus_pkg::*;

    logic       ready_q;
    logic       start;
    logic [2:0] hit;    // uart, regs, ram
    logic [2:0] sel_q;

    assign hit[0] = (bus.address & REGION_MASK) == RAM_BASE;
    assign hit[1] = (bus.address & REGION_MASK) == REGS_BASE;
    assign hit[2] = (bus.address & REGION_MASK) == UART_BASE;

    // A new request only starts while the previous one is not being answered
    assign start = (bus.read || bus.write) && !ready_q;

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            sel_q   <= '0;
        end else begin
            ready_q <= start;
            if (start)
                sel_q <= hit;
        end
    end

    assign ram_port.strobe  = start && hit[0];
    assign regs_port.strobe = start && hit[1];
    assign uart_port.strobe = start && hit[2];

    assign ram_port.offset       = bus.address[$bits(offset_t)-1:0];
    assign ram_port.write        = bus.write;
    assign ram_port.write_mask   = bus.write_mask;
    assign ram_port.write_value  = bus.write_value;
    assign regs_port.offset      = bus.address[$bits(offset_t)-1:0];
    assign regs_port.write       = bus.write;
    assign regs_port.write_mask  = bus.write_mask;
    assign regs_port.write_value = bus.write_value;
    assign uart_port.offset      = bus.address[$bits(offset_t)-1:0];
    assign uart_port.write       = bus.write;
    assign uart_port.write_mask  = bus.write_mask;
    assign uart_port.write_value = bus.write_value;

    always_comb begin
        bus.read_value = '0;  // Unmapped addresses read as zero
        if (sel_q[0])
            bus.read_value = ram_port.read_value;
        else if (sel_q[1])
            bus.read_value = regs_port.read_value;
        else if (sel_q[2])
            bus.read_value = uart_port.read_value;
    end

    assign bus.ready = ready_q;

    assert property (@(posedge pll_clk) disable iff (reset)
        $onehot0({ram_port.strobe, regs_port.strobe, uart_port.strobe}))
        else $error("More than one target strobed");

endmodule

/* design/ram.sv */
module ram (
    input logic      pll_clk,
    periph_if.target bus
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    word_t mem [RAM_WORDS];
    logic [RAM_INDEX_BITS-1:0] index;

    // Word index; higher offset bits are ignored so the RAM repeats in its region
    assign index = bus.offset[RAM_INDEX_BITS+1:2];

    always_ff @(posedge pll_clk) begin
        if (bus.strobe) begin
            if (bus.write) begin
                for (int i = 0; i < $bits(mask_t); i++) begin
                    if (bus.write_mask[i])
                        mem[index][i*8 +: 8] <= bus.write_value[i*8 +: 8];
                end
            end
            bus.read_value <= mem[index];
        end
    end

endmodule

/* design/sys_regs.sv */
module sys_regs (
    input  logic                 pll_clk,
    input  logic                 reset,
    periph_if.target             bus,
    output soc_periph_pkg::led_t leds
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    cycle_t     cycle;
    logic [1:0] reg_sel;
    logic       led_write;

    assign reg_sel   = bus.offset[3:2];
    assign led_write = bus.strobe && bus.write && bus.write_mask[0]
                       && reg_sel == REG_LEDS[3:2];

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            leds  <= '0;
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            if (led_write)
                leds <= bus.write_value[$bits(led_t)-1:0];
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus.strobe) begin
            case (reg_sel)
                REG_LEDS[3:2]:     bus.read_value <= word_t'(leds);
                REG_CYCLE_LO[3:2]: bus.read_value <= cycle[31:0];
                REG_CYCLE_HI[3:2]: bus.read_value <= cycle[63:32];
                default:           bus.read_value <= '0;
            endcase
        end
    end

endmodule

/* design/uart.sv */
module uart (
    input  logic     pll_clk,
    input  logic     reset,
    input  logic     uart_rx,
    output logic     uart_tx,
    periph_if.target bus
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    uart_tx_state_t tx_state;
    uart_rx_state_t rx_state;
    logic [UART_CNT_BITS-1:0] tx_cnt;
    logic [UART_CNT_BITS-1:0] rx_cnt;
    logic [2:0] tx_bit;
    logic [2:0] rx_bit;
    byte_t      tx_shift;
    byte_t      rx_shift;
    byte_t      rx_data;
    logic       rx_valid;
    logic [1:0] rx_sync;
    logic [1:0] reg_sel;
    logic       tx_send;
    logic       tx_busy;
    logic       rx_read;
    logic       tx_tick;
    logic       rx_tick;

    assign reg_sel = bus.offset[3:2];
    assign tx_send = bus.strobe && bus.write && bus.write_mask[0] && reg_sel == UART_DATA[3:2];
    assign rx_read = bus.strobe && !bus.write && reg_sel == UART_DATA[3:2];
    assign tx_busy = tx_state != TX_IDLE;
    assign tx_tick = tx_cnt == UART_CNT_BITS'(UART_DIV - 1);
    assign rx_tick = rx_cnt == UART_CNT_BITS'(UART_DIV - 1);

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            tx_state <= TX_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            uart_tx  <= 1'b1;
        end else begin
            tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                TX_IDLE: begin
                    tx_cnt <= '0;
                    if (tx_send) begin  // A send while busy never gets here
                        tx_shift <= bus.write_value[7:0];
                        uart_tx  <= 1'b0;
                        tx_state <= TX_START;
                    end
                end
                TX_START: if (tx_tick) begin
                    uart_tx  <= tx_shift[0];
                    tx_state <= TX_DATA;
                end
                TX_DATA: if (tx_tick) begin
                    tx_shift <= tx_shift >> 1;
                    tx_bit   <= tx_bit + 1'b1;
                    uart_tx  <= (tx_bit == 3'd7) ? 1'b1 : tx_shift[1];
                    if (tx_bit == 3'd7)
                        tx_state <= TX_STOP;
                end
                TX_STOP: if (tx_tick) tx_state <= TX_IDLE;
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (reset) begin
            rx_sync  <= 2'b11;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_cnt  <= rx_tick ? '0 : rx_cnt + 1'b1;
            if (rx_read)
                rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync[1])
                        rx_state <= RX_START;
                end
                // Half a bit in, so every later sample lands mid-bit
                RX_START: if (rx_cnt == UART_CNT_BITS'(UART_DIV / 2 - 1)) begin
                    rx_cnt   <= '0;
                    rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (rx_tick) begin
                    rx_shift <= {rx_sync[1], rx_shift[7:1]};
                    rx_bit   <= rx_bit + 1'b1;
                    if (rx_bit == 3'd7)
                        rx_state <= RX_STOP;
                end
                RX_STOP: if (rx_tick) begin
                    rx_state <= RX_IDLE;
                    if (rx_sync[1]) begin  // Bad stop bit drops the byte
                        rx_data  <= rx_shift;
                        rx_valid <= 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (bus.strobe) begin
            case (reg_sel)
                UART_DATA[3:2]:   bus.read_value <= word_t'(rx_data);
                UART_STATUS[3:2]: bus.read_value <= word_t'({rx_valid, tx_busy});
                default:          bus.read_value <= '0;
            endcase
        end
    end

    assert property (@(posedge pll_clk) disable iff (reset)
        (tx_state == TX_IDLE && !(bus.strobe && bus.write)) |=> tx_state == TX_IDLE)
        else $error("Transmitter started without a data write");

endmodule

/* design/soc_top.sv */
module soc_top (
    input  logic                 pll_clk,
    input  logic                 reset,
    input  soc_bus_pkg::addr_t   instr_address,
    input  logic                 instr_read,
    output soc_bus_pkg::word_t   instr_read_value,
    output logic                 instr_ready,
    input  soc_bus_pkg::addr_t   data_address,
    input  logic                 data_read,
    input  logic                 data_write,
    input  soc_bus_pkg::mask_t   data_write_mask,
    input  soc_bus_pkg::word_t   data_write_value,
    output soc_bus_pkg::word_t   data_read_value,
    output logic                 data_ready,
    input  logic                 uart_rx,
    output logic                 uart_tx,
    output soc_periph_pkg::led_t leds
);

    mem_bus_if mem_bus ();
    periph_if  ram_bus ();
    periph_if  regs_bus ();
    periph_if  uart_bus ();

    bus_arbiter bus_arbiter (
        .pll_clk          (pll_clk),
        .reset            (reset),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .bus              (mem_bus.host)
    );

    bus_decoder bus_decoder (
        .pll_clk   (pll_clk),
        .reset     (reset),
        .bus       (mem_bus.target),
        .ram_port  (ram_bus.host),
        .regs_port (regs_bus.host),
        .uart_port (uart_bus.host)
    );

    ram ram (
        .pll_clk (pll_clk),
        .bus     (ram_bus.target)
    );

    sys_regs sys_regs (
        .pll_clk (pll_clk),
        .reset   (reset),
        .bus     (regs_bus.target),
        .leds    (leds)
    );

    uart uart (
        .pll_clk (pll_clk),
        .reset   (reset),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .bus     (uart_bus.target)
    );

endmodule

/* sim/tb_soc_tasks.svh */
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

task automatic report_mismatch(input string what, input word_t got, input word_t expected);
    errors++;
    $display("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, expected);
endtask

task automatic end_test(input string name, input int start_errors);
    tests_run++;
    $display("%s: %s (%0d errors)", name, (errors == start_errors) ? "ok" : "failed",
             errors - start_errors);
endtask

task automatic data_access(input addr_t address, input logic is_write, input mask_t mask,
                           input word_t value, output word_t read_value, output logic ok);
    int unsigned waited;
    @(posedge pll_clk);
    #1;
    data_address     = address;
    data_read        = !is_write;
    data_write       = is_write;
    data_write_mask  = mask;
    data_write_value = value;
    waited           = 0;
    ok               = 1'b0;
    read_value       = '0;
    while (!ok && waited < READY_TIMEOUT) begin
        @(posedge pll_clk);
        #1;
        waited++;
        if (data_ready) begin
            ok         = 1'b1;
            read_value = data_read_value;  // Only valid in the ready cycle
        end
    end
    data_read       = 1'b0;
    data_write      = 1'b0;
    data_write_mask = '0;
    if (!ok) begin
        errors++;
        $display("Data port access to 0x%08h got no ready within %0d cycles",
                 address, READY_TIMEOUT);
    end
endtask

task automatic instr_fetch(input addr_t address, output word_t read_value, output logic ok);
    int unsigned waited;
    @(posedge pll_clk);
    #1;
    instr_address = address;
    instr_read    = 1'b1;
    waited        = 0;
    ok            = 1'b0;
    read_value    = '0;
    while (!ok && waited < READY_TIMEOUT) begin
        @(posedge pll_clk);
        #1;
        waited++;
        if (instr_ready) begin
            ok         = 1'b1;
            read_value = instr_read_value;
        end
    end
    instr_read = 1'b0;
    if (!ok) begin
        errors++;
        $display("Instruction fetch from 0x%08h got no ready within %0d cycles",
                 address, READY_TIMEOUT);
    end
endtask

task automatic bus_write(input addr_t address, input mask_t mask, input word_t value);
    word_t unused;
    logic  ok;
    data_access(address, 1'b1, mask, value, unused, ok);
endtask

task automatic bus_read(input addr_t address, output word_t value, output logic ok);
    data_access(address, 1'b0, '0, '0, value, ok);
endtask

// Random upper offset bits land on the same word, since the RAM repeats every RAM_WORDS
function automatic addr_t ram_address(input int unsigned index);
    addr_t address;
    address        = RAM_BASE;
    address[15:10] = 6'($urandom());
    address[9:2]   = 8'(index);
    address[1:0]   = 2'b00;
    return address;
endfunction

task automatic model_write(input addr_t address, input mask_t mask, input word_t value);
    int unsigned index;
    index = address[9:2];
    for (int lane = 0; lane < 4; lane++) begin
        if (mask[lane])
            ram_model[index][lane*8 +: 8] = value[lane*8 +: 8];
    end
endtask

task automatic wait_uart_status(input int bit_index, input logic level, output logic ok);
    int unsigned start;
    word_t       status;
    logic        read_ok;
    start = cycle_count;
    ok    = 1'b0;
    while (!ok && cycle_count - start < UART_TIMEOUT) begin
        bus_read(UART_BASE + UART_STATUS, status, read_ok);
        if (read_ok && status[bit_index] === level)
            ok = 1'b1;
    end
    if (!ok) begin
        errors++;
        $display("UART status bit %0d did not become %0b within %0d cycles",
                 bit_index, level, UART_TIMEOUT);
    end
endtask

task automatic test_reset_state();
    int start_errors;
    start_errors = errors;
    if (leds !== 8'h00)
        report_mismatch("LEDs after reset", word_t'(leds), 32'h0);
    if (instr_ready !== 1'b0 || data_ready !== 1'b0)
        report_mismatch("Ready after reset", {instr_ready, data_ready}, 32'h0);
    if (serial_line !== 1'b1)
        report_mismatch("UART line after reset", word_t'(serial_line), 32'h1);
    end_test("Reset state", start_errors);
endtask

task automatic test_ram_writes();
    int          start_errors;
    int unsigned index;
    addr_t       address;
    mask_t       mask;
    word_t       value;
    word_t       got;
    logic        ok;
    start_errors = errors;
    for (int i = 0; i < RAM_WORDS; i++) begin
        value   = {~8'(i), 8'(i), 8'h5a, 8'(i) ^ 8'h3c};
        address = ram_address(i);
        bus_write(address, 4'hf, value);
        model_write(address, 4'hf, value);
    end
    for (int n = 0; n < 40; n++) begin
        index = $urandom_range(RAM_WORDS - 1, 0);
        if (n < 4)
            index = RAM_WORDS - 1 - n;  // Top words, reached through wrapped addresses
        mask  = (n % 5 == 0) ? 4'hf : 4'($urandom());
        value = $urandom();
        address = ram_address(index);
        bus_write(address, mask, value);
        model_write(address, mask, value);
        bus_read(ram_address(index), got, ok);
        if (ok && got !== ram_model[index])
            report_mismatch("RAM word", got, ram_model[index]);
    end
    end_test("RAM writes", start_errors);
endtask

task automatic test_both_masters();
    int          start_errors;
    int unsigned instr_index;
    int unsigned data_index;
    addr_t       instr_addr;
    addr_t       data_addr;
    word_t       instr_got;
    word_t       data_got;
    logic        instr_ok;
    logic        data_ok;
    start_errors = errors;
    for (int n = 0; n < 8; n++) begin
        instr_index = $urandom_range(RAM_WORDS - 1, 0);
        instr_fetch(ram_address(instr_index), instr_got, instr_ok);
        if (instr_ok && instr_got !== ram_model[instr_index])
            report_mismatch("Instruction fetch", instr_got, ram_model[instr_index]);
    end
    for (int n = 0; n < 4; n++) begin
        instr_index = $urandom_range(RAM_WORDS - 1, 0);
        data_index  = $urandom_range(RAM_WORDS - 1, 0);
        instr_addr  = ram_address(instr_index);
        data_addr   = ram_address(data_index);
        fork  // Both requests rise on the same edge
            instr_fetch(instr_addr, instr_got, instr_ok);
            bus_read(data_addr, data_got, data_ok);
        join
        if (instr_ok && instr_got !== ram_model[instr_index])
            report_mismatch("Contended instruction fetch", instr_got, ram_model[instr_index]);
        if (data_ok && data_got !== ram_model[data_index])
            report_mismatch("Contended data read", data_got, ram_model[data_index]);
    end
    end_test("Both masters", start_errors);
endtask

task automatic test_leds();
    int    start_errors;
    word_t got;
    logic  ok;
    start_errors = errors;
    bus_write(REGS_BASE + REG_LEDS, 4'h1, 32'h0000_005a);
    if (leds !== 8'h5a)
        report_mismatch("LED output", word_t'(leds), 32'h5a);
    bus_read(REGS_BASE + REG_LEDS, got, ok);
    if (ok && got !== 32'h0000_005a)
        report_mismatch("LED register", got, 32'h5a);
    bus_write(REGS_BASE + REG_LEDS, 4'he, 32'hffff_ffff);  // Lane 0 masked off
    if (leds !== 8'h5a)
        report_mismatch("LED output after masked write", word_t'(leds), 32'h5a);
    bus_write(REGS_BASE + REG_LEDS, 4'hf, 32'h1234_56a5);
    if (leds !== 8'ha5)
        report_mismatch("LED output", word_t'(leds), 32'ha5);
    bus_read(REGS_BASE + REG_LEDS, got, ok);
    if (ok && got !== 32'h0000_00a5)
        report_mismatch("LED register", got, 32'ha5);
    end_test("LEDs", start_errors);
endtask

task automatic test_cycle_counter();
    int    start_errors;
    word_t first;
    word_t second;
    word_t high;
    logic  ok_first;
    logic  ok_second;
    logic  ok_high;
    start_errors = errors;
    bus_read(REGS_BASE + REG_CYCLE_LO, first, ok_first);
    bus_read(REGS_BASE + REG_CYCLE_LO, second, ok_second);
    if (ok_first && ok_second && !(second > first))
        report_mismatch("Second cycle count", second, first + 1);
    bus_read(REGS_BASE + REG_CYCLE_HI, high, ok_high);
    if (ok_high && high !== 32'h0)
        report_mismatch("Cycle count high word", high, 32'h0);
    end_test("Cycle counter", start_errors);
endtask

task automatic test_uart_loopback();
    int    start_errors;
    byte_t sent;
    word_t got;
    logic  ok;
    start_errors = errors;
    for (int n = 0; n < 2; n++) begin
        sent = (n == 0) ? 8'ha5 : 8'($urandom());
        wait_uart_status(0, 1'b0, ok);
        bus_write(UART_BASE + UART_DATA, 4'h1, word_t'(sent));
        wait_uart_status(1, 1'b1, ok);
        if (ok) begin
            bus_read(UART_BASE + UART_DATA, got, ok);
            if (ok && got !== word_t'(sent))
                report_mismatch("UART received byte", got, word_t'(sent));
            bus_read(UART_BASE + UART_STATUS, got, ok);
            if (ok && got[1] !== 1'b0)
                report_mismatch("UART rx_valid after read", word_t'(got[1]), 32'h0);
        end
    end
    end_test("UART loopback", start_errors);
endtask

task automatic test_unmapped();
    int    start_errors;
    word_t got;
    logic  ok;
    start_errors = errors;
    bus_read(32'h0005_0000, got, ok);
    if (ok && got !== 32'h0)
        report_mismatch("Unmapped address", got, 32'h0);
    end_test("Unmapped address", start_errors);
endtask

`endif

/* sim/tb_soc_top.sv */
module tb_soc_top;
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    localparam int unsigned READY_TIMEOUT = 50;
    localparam int unsigned UART_TIMEOUT  = 200;

    logic  pll_clk;
    logic  reset;
    addr_t instr_address;
    logic  instr_read;
    word_t instr_read_value;
    logic  instr_ready;
    addr_t data_address;
    logic  data_read;
    logic  data_write;
    mask_t data_write_mask;
    word_t data_write_value;
    word_t data_read_value;
    logic  data_ready;
    logic  serial_line;  // Transmitter looped back into the receiver
    led_t  leds;

    int          errors;
    int          tests_run;
    int unsigned cycle_count = 0;
    word_t       ram_model [RAM_WORDS];

    soc_top uut (
        .pll_clk          (pll_clk),
        .reset            (reset),
        .instr_address    (instr_address),
        .instr_read       (instr_read),
        .instr_read_value (instr_read_value),
        .instr_ready      (instr_ready),
        .data_address     (data_address),
        .data_read        (data_read),
        .data_write       (data_write),
        .data_write_mask  (data_write_mask),
        .data_write_value (data_write_value),
        .data_read_value  (data_read_value),
        .data_ready       (data_ready),
        .uart_rx          (serial_line),
        .uart_tx          (serial_line),
        .leds             (leds)
    );

    initial begin
        pll_clk = 1'b0;
        forever #2 pll_clk = ~pll_clk;
    end

    always @(posedge pll_clk) begin
        cycle_count <= cycle_count + 1;
    end

    `include "tb_soc_tasks.svh"

    initial begin
        void'($urandom(1));
        errors           = 0;
        tests_run        = 0;
        reset            = 1'b1;
        instr_address    = '0;
        instr_read       = 1'b0;
        data_address     = '0;
        data_read        = 1'b0;
        data_write       = 1'b0;
        data_write_mask  = '0;
        data_write_value = '0;
        repeat (3) @(posedge pll_clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_ram_writes();
        test_both_masters();
        test_leds();
        test_cycle_counter();
        test_uart_loopback();
        test_unmapped();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/bus_ifs.sv
design/bus_arbiter.sv
design/bus_decoder.sv
design/ram.sv
design/sys_regs.sv
design/uart.sv
design/soc_top.sv
+incdir+sim
sim/tb_soc_top.sv
